// ==== common/rv_id_pkg.sv ====
package rv_id_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;     // Data and address word
	typedef logic [4:0]      reg_addr_t; // Register index
	typedef logic [31:0]     inst_t;

	// ------------------------------
	// Major opcodes, kept groups only
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

	localparam reg_addr_t NOP_REG = 5'd0; // x0, target of no-write ops

	// ------------------------------
	typedef enum logic [7:0] {
		ALU_NOP = 8'd0,
		ALU_LUI,
		ALU_AUIPC,
		ALU_JUMP_BRANCH,
		ALU_LB,
		ALU_LH,
		ALU_LW,
		ALU_LBU,
		ALU_LHU,
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} aluop_e;

	typedef enum logic [2:0] {
		RES_NOP = 3'd0,
		RES_LOGIC,
		RES_SHIFT,
		RES_ARITH,
		RES_UPPER_IMM,
		RES_JUMP_BRANCH,
		RES_LOAD
	} alusel_e;

	// ------------------------------
	typedef struct packed {
		reg_addr_t wd;
		logic      wreg;
		aluop_e    aluop;
		alusel_e   alusel;
		logic      reg1_read;
		logic      reg2_read; // Low means the operand is the immediate
		word_t     imm;
		logic      instvalid;
	} id_ctrl_t;

	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
	} fwd_t;

	typedef struct packed {
		aluop_e    aluop;
		alusel_e   alusel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
		word_t     link_addr;
	} id_ex_t;

	localparam id_ctrl_t CTRL_INVALID = '{
		wd: NOP_REG, wreg: 1'b0, aluop: ALU_NOP, alusel: RES_NOP,
		reg1_read: 1'b0, reg2_read: 1'b0, imm: '0, instvalid: 1'b0
	};

	localparam id_ex_t EX_BUBBLE = '{
		aluop: ALU_NOP, alusel: RES_NOP, reg1: '0, reg2: '0,
		wd: NOP_REG, wreg: 1'b0, link_addr: '0
	};

endpackage

// ==== hw/id_stage/id_branch_resolve.sv ====
module id_branch_resolve (
	input  rv_id_pkg::id_ctrl_t ctrl_i,
	input  rv_id_pkg::inst_t    inst_i,
	input  rv_id_pkg::word_t    pc_i,
	input  rv_id_pkg::word_t    reg1_i,
	input  rv_id_pkg::word_t    reg2_i,
	output logic                branch_flag_o,
	output rv_id_pkg::word_t    branch_tar_o,
	output rv_id_pkg::word_t    link_addr_o
);
	import rv_id_pkg::*;

	logic [6:0] opcode;
	logic       taken;
	logic       backward; // Fetch already predicted taken
	logic       is_branch;
	logic       is_jalr;
	word_t      pc_plus_4;
	word_t      b_off;
	word_t      jalr_sum;

	assign opcode    = inst_i[6:0];
	assign backward  = inst_i[31];
	assign is_branch = ctrl_i.instvalid && (opcode == OPC_BRANCH);
	assign is_jalr   = ctrl_i.instvalid && (opcode == OPC_JALR);
	assign pc_plus_4 = pc_i + 32'd4;
	assign b_off     = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign jalr_sum  = reg1_i + ctrl_i.imm;

	always_comb begin
		case (inst_i[14:12])
			3'b000:  taken = (reg1_i == reg2_i);
			3'b001:  taken = (reg1_i != reg2_i);
			3'b100:  taken = ($signed(reg1_i) < $signed(reg2_i));
			3'b101:  taken = ($signed(reg1_i) >= $signed(reg2_i));
			3'b110:  taken = (reg1_i < reg2_i);
			default: taken = (reg1_i >= reg2_i); // BGEU
		endcase
	end

	// Redirect only where the static guess was wrong
	always_comb begin
		branch_flag_o = 1'b0;
		branch_tar_o  = '0;
		if (is_branch && taken && !backward) begin
			branch_flag_o = 1'b1;
			branch_tar_o  = pc_i + b_off;
		end else if (is_branch && !taken && backward) begin
			branch_flag_o = 1'b1;
			branch_tar_o  = pc_plus_4; // Back to fall-through
		end else if (is_jalr) begin
			branch_flag_o = 1'b1;
			branch_tar_o  = {jalr_sum[XLEN-1:1], 1'b0};
		end
	end

	assign link_addr_o = (ctrl_i.instvalid && (opcode == OPC_JAL || opcode == OPC_JALR)) ?
		pc_plus_4 : '0;

endmodule

// ==== hw/id_stage/id_decoder.sv ====
module id_decoder (
	input  rv_id_pkg::inst_t    inst_i,
	output rv_id_pkg::id_ctrl_t ctrl_o
);
	import rv_id_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t  rd;
	logic       alt;      // funct7 selects SUB/SRA
	logic       imm_ok;   // funct7 legal for OP-IMM
	logic       op_ok;    // funct7 legal for OP
	word_t      imm_u;
	word_t      imm_i;
	word_t      imm_sh;

	// OP and OP-IMM share the funct3 meaning
	function automatic aluop_e alu_op_of(input logic [2:0] f3, input logic use_alt);
		case (f3)
			3'b000:  alu_op_of = use_alt ? ALU_SUB : ALU_ADD;
			3'b001:  alu_op_of = ALU_SLL;
			3'b010:  alu_op_of = ALU_SLT;
			3'b011:  alu_op_of = ALU_SLTU;
			3'b100:  alu_op_of = ALU_XOR;
			3'b101:  alu_op_of = use_alt ? ALU_SRA : ALU_SRL;
			3'b110:  alu_op_of = ALU_OR;
			default: alu_op_of = ALU_AND;
		endcase
	endfunction

	function automatic alusel_e res_of(input aluop_e op);
		case (op)
			ALU_SLL, ALU_SRL, ALU_SRA: res_of = RES_SHIFT;
			ALU_XOR, ALU_OR, ALU_AND:  res_of = RES_LOGIC;
			default:                   res_of = RES_ARITH;
		endcase
	endfunction

	assign opcode = inst_i[6:0];
	assign rd     = inst_i[11:7];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign alt    = (funct7 == F7_ALT);

	assign imm_u  = {inst_i[31:12], 12'h000};
	assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_sh = {27'd0, inst_i[24:20]}; // shamt, zero extended

	assign imm_ok = (funct3 == 3'b001) ? (funct7 == F7_BASE) :
		(funct3 == 3'b101) ? (funct7 == F7_BASE || alt) : 1'b1;
	assign op_ok = (funct7 == F7_BASE) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));

	always_comb begin
		ctrl_o = CTRL_INVALID; // Anything not matched below
		case (opcode)
			OPC_LUI, OPC_AUIPC: begin
				ctrl_o.instvalid = 1'b1;
				ctrl_o.wreg      = 1'b1;
				ctrl_o.aluop     = (opcode == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
				ctrl_o.alusel    = RES_UPPER_IMM;
				ctrl_o.imm       = imm_u;
			end
			OPC_JAL: begin
				ctrl_o.instvalid = 1'b1;
				ctrl_o.wreg      = 1'b1;
				ctrl_o.aluop     = ALU_JUMP_BRANCH;
				ctrl_o.alusel    = RES_JUMP_BRANCH;
			end
			OPC_JALR: if (funct3 == 3'b000) begin
				ctrl_o.instvalid = 1'b1;
				ctrl_o.wreg      = 1'b1;
				ctrl_o.aluop     = ALU_JUMP_BRANCH;
				ctrl_o.alusel    = RES_JUMP_BRANCH;
				ctrl_o.reg1_read = 1'b1;
				ctrl_o.imm       = imm_i; // Target offset
			end
			OPC_BRANCH: if (funct3 != 3'b010 && funct3 != 3'b011) begin
				ctrl_o.instvalid = 1'b1;
				ctrl_o.aluop     = ALU_JUMP_BRANCH;
				ctrl_o.alusel    = RES_JUMP_BRANCH;
				ctrl_o.reg1_read = 1'b1;
				ctrl_o.reg2_read = 1'b1;
			end
			OPC_LOAD: begin
				ctrl_o.instvalid = 1'b1;
				ctrl_o.wreg      = 1'b1;
				ctrl_o.alusel    = RES_LOAD;
				ctrl_o.reg1_read = 1'b1;
				ctrl_o.imm       = imm_i; // Address offset
				case (funct3)
					3'b000:  ctrl_o.aluop = ALU_LB;
					3'b001:  ctrl_o.aluop = ALU_LH;
					3'b010:  ctrl_o.aluop = ALU_LW;
					3'b100:  ctrl_o.aluop = ALU_LBU;
					3'b101:  ctrl_o.aluop = ALU_LHU;
					default: ctrl_o = CTRL_INVALID;
				endcase
			end
			OPC_OP_IMM: if (imm_ok) begin
				ctrl_o.instvalid = 1'b1;
				ctrl_o.wreg      = 1'b1;
				ctrl_o.reg1_read = 1'b1;
				ctrl_o.aluop     = alu_op_of(funct3, alt && funct3 == 3'b101);
				ctrl_o.alusel    = res_of(ctrl_o.aluop);
				ctrl_o.imm       = (funct3 == 3'b001 || funct3 == 3'b101) ? imm_sh : imm_i;
			end
			OPC_OP: if (op_ok) begin
				ctrl_o.instvalid = 1'b1;
				ctrl_o.wreg      = 1'b1;
				ctrl_o.reg1_read = 1'b1;
				ctrl_o.reg2_read = 1'b1;
				ctrl_o.aluop     = alu_op_of(funct3, alt);
				ctrl_o.alusel    = res_of(ctrl_o.aluop);
			end
			default: ;
		endcase
		ctrl_o.wd = ctrl_o.wreg ? rd : NOP_REG;
	end

	wreg_needs_valid_a: assert final (!ctrl_o.wreg || ctrl_o.instvalid);

endmodule

// ==== hw/id_stage/id_ex_reg.sv ====
module id_ex_reg (
	input  logic                clk,
	input  logic                rst_n_i,
	input  rv_id_pkg::id_ctrl_t ctrl_i,
	input  rv_id_pkg::word_t    reg1_i,
	input  rv_id_pkg::word_t    reg2_i,
	input  rv_id_pkg::word_t    link_addr_i,
	input  logic                stall_i,
	output rv_id_pkg::id_ex_t   ex_o
);
	import rv_id_pkg::*;

	id_ex_t ex_next;

	assign ex_next = '{
		aluop:     ctrl_i.aluop,
		alusel:    ctrl_i.alusel,
		reg1:      reg1_i,
		reg2:      reg2_i,
		wd:        ctrl_i.wd,
		wreg:      ctrl_i.wreg,
		link_addr: link_addr_i
	};

	// ------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_o <= EX_BUBBLE;
		end else if (stall_i) begin
			ex_o <= EX_BUBBLE; // Decode is held, execute gets a NOP
		end else begin
			ex_o <= ex_next;
		end
	end

	// A stalled instruction must not reach execute as a write
	no_write_after_stall_a: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		stall_i |=> !ex_o.wreg
	);

endmodule

// ==== hw/id_stage/id_operand_fwd.sv ====
module id_operand_fwd (
	input  rv_id_pkg::id_ctrl_t  ctrl_i,
	input  rv_id_pkg::inst_t     inst_i,
	input  rv_id_pkg::word_t     reg1_data_i,
	input  rv_id_pkg::word_t     reg2_data_i,
	input  rv_id_pkg::fwd_t      ex_fwd_i,
	input  rv_id_pkg::fwd_t      mem_fwd_i,
	input  rv_id_pkg::aluop_e    ex_aluop_i,
	output rv_id_pkg::word_t     reg1_o,
	output rv_id_pkg::word_t     reg2_o,
	output rv_id_pkg::reg_addr_t reg1_addr_o,
	output rv_id_pkg::reg_addr_t reg2_addr_o,
	output logic                 stall_o
);
	import rv_id_pkg::*;

	logic ex_is_load;
	logic hazard1;
	logic hazard2;

	// Youngest producer wins
	function automatic word_t pick_operand(
		input logic      rd_en,
		input reg_addr_t addr,
		input word_t     rf_data,
		input word_t     imm,
		input fwd_t      ex_fwd,
		input fwd_t      mem_fwd
	);
		if (!rd_en)
			return imm;
		if (ex_fwd.wreg && ex_fwd.wd == addr)
			return ex_fwd.wdata;
		if (mem_fwd.wreg && mem_fwd.wd == addr)
			return mem_fwd.wdata;
		return rf_data;
	endfunction

	assign reg1_addr_o = inst_i[19:15]; // rs1
	assign reg2_addr_o = inst_i[24:20]; // rs2

	assign reg1_o = pick_operand(ctrl_i.reg1_read, reg1_addr_o, reg1_data_i,
		ctrl_i.imm, ex_fwd_i, mem_fwd_i);
	assign reg2_o = pick_operand(ctrl_i.reg2_read, reg2_addr_o, reg2_data_i,
		ctrl_i.imm, ex_fwd_i, mem_fwd_i);

	// ------------------------------
	// Load data not ready until after execute
	assign ex_is_load = ex_aluop_i inside {ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU};
	assign hazard1    = ctrl_i.reg1_read && (ex_fwd_i.wd == reg1_addr_o);
	assign hazard2    = ctrl_i.reg2_read && (ex_fwd_i.wd == reg2_addr_o);
	assign stall_o    = ex_is_load && (hazard1 || hazard2);

endmodule

// ==== hw/id_stage/id_stage.sv ====
module id_stage (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  rv_id_pkg::word_t      pc_i,
	input  rv_id_pkg::inst_t      inst_i,
	input  rv_id_pkg::word_t      reg1_data_i,
	input  rv_id_pkg::word_t      reg2_data_i,
	input  rv_id_pkg::fwd_t       ex_fwd_i,
	input  rv_id_pkg::fwd_t       mem_fwd_i,
	input  rv_id_pkg::aluop_e     ex_aluop_i,
	output rv_id_pkg::reg_addr_t  reg1_addr_o,
	output rv_id_pkg::reg_addr_t  reg2_addr_o,
	output logic                  stallreq_o,
	output logic                  branch_flag_o,
	output rv_id_pkg::word_t      branch_tar_o,
	output rv_id_pkg::id_ex_t     ex_o
);
	import rv_id_pkg::*;

	id_ctrl_t ctrl;
	word_t    reg1;      // Operands after forwarding
	word_t    reg2;
	word_t    link_addr;
	logic     stall;

	id_decoder u_decoder (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	id_operand_fwd u_operand_fwd (
		.ctrl_i      (ctrl),
		.inst_i      (inst_i),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.ex_fwd_i    (ex_fwd_i),
		.mem_fwd_i   (mem_fwd_i),
		.ex_aluop_i  (ex_aluop_i),
		.reg1_o      (reg1),
		.reg2_o      (reg2),
		.reg1_addr_o (reg1_addr_o),
		.reg2_addr_o (reg2_addr_o),
		.stall_o     (stall)
	);

	id_branch_resolve u_branch_resolve (
		.ctrl_i        (ctrl),
		.inst_i        (inst_i),
		.pc_i          (pc_i),
		.reg1_i        (reg1),
		.reg2_i        (reg2),
		.branch_flag_o (branch_flag_o),
		.branch_tar_o  (branch_tar_o),
		.link_addr_o   (link_addr)
	);

	id_ex_reg u_ex_reg (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ctrl_i      (ctrl),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.link_addr_i (link_addr),
		.stall_i     (stall),
		.ex_o        (ex_o)
	);

	assign stallreq_o = stall;

endmodule

// ==== id_stage.f ====
common/rv_id_pkg.sv
hw/id_stage/id_decoder.sv
hw/id_stage/id_operand_fwd.sv
hw/id_stage/id_branch_resolve.sv
hw/id_stage/id_ex_reg.sv
hw/id_stage/id_stage.sv
tb/id_checker.sv
tb/tb_id_stage.sv

// ==== tb/id_cases.txt ====
# rnd pc inst rf1 rf2 ex_wreg ex_wd ex_wdata mem_wreg mem_wd mem_wdata ex_aluop stall bflag btar
# then expected ex_o: aluop alusel reg1 reg2 wd wreg link_addr (all hex, rnd=1 means random rf)
0 100 06408293 10 20 0 0 0 0 0 0 0 0 0 0 09 3 10 64 05 1 0
0 104 40310333 50 8 0 0 0 0 0 0 0 0 0 0 0a 3 50 8 06 1 0
0 108 fff0f393 1234 0 0 0 0 0 0 0 0 0 0 0 0f 1 1234 ffffffff 07 1 0
0 10c 0040d413 80000000 0 0 0 0 0 0 0 0 0 0 0 11 2 80000000 4 08 1 0
0 110 4030d493 80000000 0 0 0 0 0 0 0 0 0 0 0 12 2 80000000 3 09 1 0
0 114 00209533 1 5 0 0 0 0 0 0 0 0 0 0 10 2 1 5 0a 1 0
0 118 002085b3 1 2 1 1 aaaa 1 1 bbbb 9 0 0 0 09 3 aaaa 2 0b 1 0
0 118 002085b3 1 2 1 3 aaaa 1 1 bbbb 9 0 0 0 09 3 bbbb 2 0b 1 0
0 118 002085b3 1 2 0 1 aaaa 1 4 bbbb 0 0 0 0 09 3 1 2 0b 1 0
0 11c 002085b3 1 2 1 2 dead 0 0 0 6 1 0 0 09 3 1 dead 0b 1 0
0 11c 002085b3 1 2 0 0 0 1 2 5555 0 0 0 0 09 3 1 5555 0b 1 0
0 120 0040a603 40 0 0 0 0 0 0 0 0 0 0 0 06 6 40 4 0c 1 0
0 124 0040c603 40 0 0 0 0 0 0 0 0 0 0 0 07 6 40 4 0c 1 0
0 200 00208863 5 5 0 0 0 0 0 0 0 0 1 210 03 5 5 5 00 0 0
0 200 fe209ce3 5 5 0 0 0 0 0 0 0 0 1 204 03 5 5 5 00 0 0
0 200 0020c863 ffffffff 1 0 0 0 0 0 0 0 0 1 210 03 5 ffffffff 1 00 0 0
0 200 fe20dce3 ffffffff 1 0 0 0 0 0 0 0 0 1 204 03 5 ffffffff 1 00 0 0
0 200 0020e863 1 ffffffff 0 0 0 0 0 0 0 0 1 210 03 5 1 ffffffff 00 0 0
0 200 0020f863 ffffffff 1 0 0 0 0 0 0 0 0 1 210 03 5 ffffffff 1 00 0 0
0 200 00208863 5 6 0 0 0 0 0 0 0 0 0 0 03 5 5 6 00 0 0
0 200 fe209ce3 5 6 0 0 0 0 0 0 0 0 0 0 03 5 5 6 00 0 0
1 300 100000ef 0 0 0 0 0 0 0 0 0 0 0 0 03 5 0 0 01 1 304
0 400 009280e7 1000 0 0 0 0 0 0 0 0 0 1 1008 03 5 1000 9 01 1 404
1 500 123451b7 0 0 0 0 0 0 0 0 0 0 0 0 01 4 12345000 12345000 03 1 0
1 504 fffff217 0 0 0 0 0 0 0 0 0 0 0 0 02 4 fffff000 fffff000 04 1 0
1 508 0020a223 0 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 00 0 0
1 50c 00000073 0 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 00 0 0

// ==== tb/id_checker.sv ====
module id_checker (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  case_valid_i,
	input  logic                  exp_stall_i,
	input  logic                  exp_bflag_i,
	input  rv_id_pkg::word_t      exp_btar_i,
	input  rv_id_pkg::id_ex_t     exp_ex_i,
	input  rv_id_pkg::inst_t      inst_i,
	input  rv_id_pkg::reg_addr_t  reg1_addr_i,
	input  rv_id_pkg::reg_addr_t  reg2_addr_i,
	input  logic                  stallreq_i,
	input  logic                  branch_flag_i,
	input  rv_id_pkg::word_t      branch_tar_i,
	input  rv_id_pkg::id_ex_t     ex_i,
	output int                    checks_o,
	output int                    errors_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import rv_id_pkg::*;

	int     n_checks = 0;
	int     n_errors = 0;
	id_ex_t ex_prev = '0; // What ex_o must hold after the next edge

	assign checks_o = n_checks;
	assign errors_o = n_errors;

	task automatic compare_value(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		n_checks++;
		if (actv !== expv) begin
			n_errors++;
			$display("** Error @ %0t: %s expected %h got %h", $time, name, expv, actv);
		end
	endtask

	task automatic check_ex(input id_ex_t expv);
		compare_value("ex_o.aluop", 32'(expv.aluop), 32'(ex_i.aluop));
		compare_value("ex_o.alusel", 32'(expv.alusel), 32'(ex_i.alusel));
		compare_value("ex_o.reg1", expv.reg1, ex_i.reg1);
		compare_value("ex_o.reg2", expv.reg2, ex_i.reg2);
		compare_value("ex_o.wd", 32'(expv.wd), 32'(ex_i.wd));
		compare_value("ex_o.wreg", 32'(expv.wreg), 32'(ex_i.wreg));
		compare_value("ex_o.link_addr", expv.link_addr, ex_i.link_addr);
	endtask

	// ------------------------------
	// Sample mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (rst_n_i) begin
			check_ex(ex_prev);
			if (case_valid_i) begin
				compare_value("reg1_addr_o", 32'(inst_i[19:15]), 32'(reg1_addr_i)); // rs1
				compare_value("reg2_addr_o", 32'(inst_i[24:20]), 32'(reg2_addr_i)); // rs2
				compare_value("stallreq_o", 32'(exp_stall_i), 32'(stallreq_i));
				compare_value("branch_flag_o", 32'(exp_bflag_i), 32'(branch_flag_i));
				compare_value("branch_tar_o", exp_btar_i, branch_tar_i);
			end
		end
		if (case_valid_i && !exp_stall_i)
			ex_prev = exp_ex_i;
		else
			ex_prev = '0; // Bubble
	end

endmodule

// ==== tb/tb_id_stage.sv ====
module tb_id_stage;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_id_pkg::*;

	typedef struct packed {
		logic   rnd;     // Fill register-file data with random values
		word_t  pc;
		inst_t  inst;
		word_t  rf1;
		word_t  rf2;
		fwd_t   exf;
		fwd_t   memf;
		aluop_e exop;
		logic   stall;
		logic   bflag;
		word_t  btar;
		id_ex_t ex;      // Result expected in ex_o one cycle later
	} case_t;

	logic      clk;
	logic      rst_n_i;
	word_t     pc;
	inst_t     inst;
	word_t     reg1_data;
	word_t     reg2_data;
	fwd_t      ex_fwd;
	fwd_t      mem_fwd;
	aluop_e    ex_aluop;
	reg_addr_t reg1_addr;
	reg_addr_t reg2_addr;
	logic      stallreq;
	logic      branch_flag;
	word_t     branch_tar;
	id_ex_t    ex_out;

	logic      case_valid;
	logic      exp_stall;
	logic      exp_bflag;
	word_t     exp_btar;
	id_ex_t    exp_ex;

	case_t     cases[$];
	int        file_errors = 0;
	int        checks;
	int        errors;
	int        cycles = 0;
	int        cycle_limit = 0;
	int        seed = 32143;
	int        total;

	id_stage u_dut (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.pc_i          (pc),
		.inst_i        (inst),
		.reg1_data_i   (reg1_data),
		.reg2_data_i   (reg2_data),
		.ex_fwd_i      (ex_fwd),
		.mem_fwd_i     (mem_fwd),
		.ex_aluop_i    (ex_aluop),
		.reg1_addr_o   (reg1_addr),
		.reg2_addr_o   (reg2_addr),
		.stallreq_o    (stallreq),
		.branch_flag_o (branch_flag),
		.branch_tar_o  (branch_tar),
		.ex_o          (ex_out)
	);

	id_checker u_checker (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.case_valid_i  (case_valid),
		.exp_stall_i   (exp_stall),
		.exp_bflag_i   (exp_bflag),
		.exp_btar_i    (exp_btar),
		.exp_ex_i      (exp_ex),
		.inst_i        (inst),
		.reg1_addr_i   (reg1_addr),
		.reg2_addr_i   (reg2_addr),
		.stallreq_i    (stallreq),
		.branch_flag_i (branch_flag),
		.branch_tar_i  (branch_tar),
		.ex_i          (ex_out),
		.checks_o      (checks),
		.errors_o      (errors)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ------------------------------
	task automatic load_cases();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [22];
		case_t       c;
		fd = $fopen("tb/id_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file tb/id_cases.txt");
			file_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#")
				continue; // Blank or column legend
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
				f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21]);
			if (n != 22) begin
				$display("Malformed line in case file, only %0d fields: %s", n, line);
				file_errors++;
			end else begin
				c.rnd          = f[0][0];
				c.pc           = f[1];
				c.inst         = f[2];
				c.rf1          = f[3];
				c.rf2          = f[4];
				c.exf          = '{wreg: f[5][0], wd: f[6][4:0], wdata: f[7]};
				c.memf         = '{wreg: f[8][0], wd: f[9][4:0], wdata: f[10]};
				c.exop         = aluop_e'(f[11][7:0]);
				c.stall        = f[12][0];
				c.bflag        = f[13][0];
				c.btar         = f[14];
				c.ex.aluop     = aluop_e'(f[15][7:0]);
				c.ex.alusel    = alusel_e'(f[16][2:0]);
				c.ex.reg1      = f[17];
				c.ex.reg2      = f[18];
				c.ex.wd        = f[19][4:0];
				c.ex.wreg      = f[20][0];
				c.ex.link_addr = f[21];
				cases.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	task automatic apply_case(input case_t c);
		pc         <= c.pc;
		inst       <= c.inst;
		reg1_data  <= c.rnd ? word_t'($urandom) : c.rf1; // Filler the decoder ignores
		reg2_data  <= c.rnd ? word_t'($urandom) : c.rf2;
		ex_fwd     <= c.exf;
		mem_fwd    <= c.memf;
		ex_aluop   <= c.exop;
		case_valid <= 1'b1;
		exp_stall  <= c.stall;
		exp_bflag  <= c.bflag;
		exp_btar   <= c.btar;
		exp_ex     <= c.ex;
	endtask

	task automatic idle_inputs();
		pc         <= '0;
		inst       <= '0; // Opcode 0 decodes as invalid
		reg1_data  <= '0;
		reg2_data  <= '0;
		ex_fwd     <= '0;
		mem_fwd    <= '0;
		ex_aluop   <= ALU_NOP;
		case_valid <= 1'b0;
		exp_stall  <= 1'b0;
		exp_bflag  <= 1'b0;
		exp_btar   <= '0;
		exp_ex     <= '0;
	endtask

	// ------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("Timeout: run still going after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		void'($urandom(seed));
		rst_n_i <= 1'b0;
		idle_inputs();
		load_cases();
		cycle_limit = cases.size() + 20;
		if (cases.size() == 0) begin
			$display("No cases were read from the case file");
			file_errors++;
		end
		repeat (5) @(posedge clk);
		rst_n_i <= 1'b1;
		@(posedge clk); // Idle cycle where ex_o is still a bubble
		foreach (cases[i]) begin
			apply_case(cases[i]);
			@(posedge clk);
		end
		idle_inputs();
		repeat (2) @(negedge clk);
		@(posedge clk);
		total = errors + file_errors;
		$display("%0d cases, %0d checks, %0d errors, %0d case file errors",
			cases.size(), checks, errors, file_errors);
		if (total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
